// ==== source/lsuPkg.sv ====
package lsuPkg;

    localparam int SqnWidth = 6;   // sequence numbers wrap, age comes from a signed difference
    localparam int TagWidth = 5;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [1:0] AXI_OKAY = 2'b00;   // anything else is reported as an error

    // states of the memory port FSM
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_WRITE  = 3'd1;   // aw and w raised together
    localparam logic [2:0] ST_WAIT_B = 3'd2;
    localparam logic [2:0] ST_READ   = 3'd3;
    localparam logic [2:0] ST_WAIT_R = 3'd4;
    localparam logic [2:0] ST_DONE   = 3'd5;   // result pulse

    typedef enum logic [3:0] {
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW,
        LSU_NONE
    } lsuOp;

    // the same word is read as I-type by loads and as S-type by stores
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } itype;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } stype;
    } instrWord;

endpackage

// ==== source/loadAlign.sv ====
module loadAlign (
    input  logic [31:0] raw,
    input  logic [1:0]  shamt,
    input  logic [1:0]  size,
    input  logic        signExtend,
    output logic [31:0] value
);

    logic [31:0] shifted;
    logic        fillBit;

    // bring the addressed byte or half down to bit 0
    assign shifted = raw >> {shamt, 3'b000};

    always_comb begin
        fillBit = 1'b0;
        case (size)
            2'd0: begin
                fillBit = signExtend && shifted[7];
                value   = {{24{fillBit}}, shifted[7:0]};
            end
            2'd1: begin
                fillBit = signExtend && shifted[15];
                value   = {{16{fillBit}}, shifted[15:0]};
            end
            default: begin
                value = shifted;   // word loads are never shifted
            end
        endcase
    end

endmodule

// ==== source/lsuDecode.sv ====
module lsuDecode import lsuPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flushValid,
    input  logic [SqnWidth-1:0] flushSqn,
    input  logic                issueValid,
    input  instrWord            instr,
    input  logic [31:0]         srcA,
    input  logic [31:0]         srcB,
    input  logic [SqnWidth-1:0] sqn,
    input  logic [TagWidth-1:0] tag,
    input  logic                outReady,
    output logic                issueReady,
    output logic                outValid,
    output lsuOp                op,
    output logic [31:0]         base,
    output logic [31:0]         imm,
    output logic [31:0]         storeData,
    output logic [SqnWidth-1:0] outSqn,
    output logic [TagWidth-1:0] outTag
);

    lsuOp        decOp;
    logic [31:0] decImm;
    logic        inYounger;
    logic        heldYounger;

    assign inYounger   = flushValid && ($signed(sqn - flushSqn) > 0);
    assign heldYounger = flushValid && ($signed(outSqn - flushSqn) > 0);

    assign issueReady = !outValid || outReady;   // free, or our op moves on this cycle

    always_comb begin
        decOp  = LSU_NONE;
        decImm = {{20{instr.itype.imm[11]}}, instr.itype.imm};
        if (instr.itype.opcode == OPC_LOAD) begin
            case (instr.itype.funct3)
                3'b000:  decOp = LSU_LB;
                3'b001:  decOp = LSU_LH;
                3'b010:  decOp = LSU_LW;
                3'b100:  decOp = LSU_LBU;
                3'b101:  decOp = LSU_LHU;
                default: decOp = LSU_NONE;
            endcase
        end else if (instr.stype.opcode == OPC_STORE) begin
            // store immediate is split around rs2/rs1
            decImm = {{20{instr.stype.immHi[6]}}, instr.stype.immHi, instr.stype.immLo};
            case (instr.stype.funct3)
                3'b000:  decOp = LSU_SB;
                3'b001:  decOp = LSU_SH;
                3'b010:  decOp = LSU_SW;
                default: decOp = LSU_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (issueValid && issueReady && !inYounger) begin
            outValid <= (decOp != LSU_NONE);   // other instruction words vanish here
        end else if (outReady || heldYounger) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid && issueReady) begin
            op        <= decOp;
            base      <= srcA;
            imm       <= decImm;
            storeData <= srcB;
            outSqn    <= sqn;
            outTag    <= tag;
        end
    end

endmodule

// ==== source/addrGen.sv ====
module addrGen import lsuPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flushValid,
    input  logic [SqnWidth-1:0] flushSqn,
    input  logic                inValid,
    input  lsuOp                op,
    input  logic [31:0]         base,
    input  logic [31:0]         imm,
    input  logic [31:0]         storeData,
    input  logic [SqnWidth-1:0] inSqn,
    input  logic [TagWidth-1:0] inTag,
    input  logic                outReady,
    output logic                inReady,
    output logic                outValid,
    output logic [31:0]         addr,
    output logic [3:0]          wmask,
    output logic [31:0]         wdata,
    output logic [1:0]          shamt,
    output logic [1:0]          size,
    output logic                signExtend,
    output logic                isLoad,
    output logic [SqnWidth-1:0] outSqn,
    output logic [TagWidth-1:0] outTag
);

    logic [31:0] effAddr;
    logic        inYounger;
    logic        heldYounger;

    assign effAddr = base + imm;

    assign inYounger   = flushValid && ($signed(inSqn - flushSqn) > 0);
    assign heldYounger = flushValid && ($signed(outSqn - flushSqn) > 0);

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inValid && inReady && !inYounger) begin
            outValid <= 1'b1;
        end else if (outReady || heldYounger) begin
            outValid <= 1'b0;   // handed on, or squashed by the branch
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            addr   <= effAddr;
            outSqn <= inSqn;
            outTag <= inTag;

            // misaligned lanes wrap inside the word, no trap
            case (op)
                LSU_LB, LSU_LBU: begin
                    isLoad     <= 1'b1;
                    shamt      <= effAddr[1:0];
                    size       <= 2'd0;
                    signExtend <= (op == LSU_LB);
                    wmask      <= 4'b0000;
                end
                LSU_LH, LSU_LHU: begin
                    isLoad     <= 1'b1;
                    shamt      <= {effAddr[1], 1'b0};
                    size       <= 2'd1;
                    signExtend <= (op == LSU_LH);
                    wmask      <= 4'b0000;
                end
                LSU_LW: begin
                    isLoad     <= 1'b1;
                    shamt      <= 2'd0;
                    size       <= 2'd2;
                    signExtend <= 1'b0;
                    wmask      <= 4'b0000;
                end
                LSU_SB: begin
                    isLoad <= 1'b0;
                    wmask  <= 4'b0001 << effAddr[1:0];   // one-hot byte lane
                    wdata  <= storeData << {effAddr[1:0], 3'b000};
                end
                LSU_SH: begin
                    isLoad <= 1'b0;
                    wmask  <= effAddr[1] ? 4'b1100 : 4'b0011;
                    wdata  <= storeData << {effAddr[1], 4'b0000};
                end
                LSU_SW: begin
                    isLoad <= 1'b0;
                    wmask  <= 4'b1111;
                    wdata  <= storeData;
                end
                default: begin
                    isLoad <= 1'b0;
                    wmask  <= 4'b0000;
                end
            endcase
        end
    end

endmodule

// ==== source/memPort.sv ====
module memPort import lsuPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  logic [31:0]         addr,
    input  logic [3:0]          wmask,
    input  logic [31:0]         inWdata,
    input  logic [1:0]          shamt,
    input  logic [1:0]          size,
    input  logic                signExtend,
    input  logic                isLoad,
    input  logic [SqnWidth-1:0] inSqn,
    input  logic [TagWidth-1:0] inTag,
    output logic                inReady,
    output logic [31:0]         awaddr,
    output logic                awvalid,
    input  logic                awready,
    output logic [31:0]         wdata,
    output logic [3:0]          wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready,
    output logic [31:0]         araddr,
    output logic                arvalid,
    input  logic                arready,
    input  logic [31:0]         rdata,
    input  logic [1:0]          rresp,
    input  logic                rvalid,
    output logic                rready,
    output logic                resultValid,
    output logic [31:0]         resultData,
    output logic [TagWidth-1:0] resultTag,
    output logic [SqnWidth-1:0] resultSqn,
    output logic                resultIsLoad,
    output logic                resultErr
);

    logic [2:0]  state;
    logic [31:0] busAddr;
    logic [1:0]  shamtReg;
    logic [1:0]  sizeReg;
    logic        signReg;
    logic [31:0] loadValue;

    assign inReady     = (state == ST_IDLE);   // one access at a time
    assign awaddr      = busAddr;
    assign araddr      = busAddr;
    assign bready      = 1'b1;
    assign rready      = 1'b1;
    assign resultValid = (state == ST_DONE);

    loadAlign align (
        .raw        (rdata),
        .shamt      (shamtReg),
        .size       (sizeReg),
        .signExtend (signReg),
        .value      (loadValue)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (inValid && isLoad) begin
                        arvalid <= 1'b1;
                        state   <= ST_READ;
                    end else if (inValid) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    // aw and w may be taken in either order
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready)) state <= ST_WAIT_B;
                end
                ST_WAIT_B: if (bvalid) state <= ST_DONE;
                ST_READ: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= ST_WAIT_R;
                    end
                end
                ST_WAIT_R: if (rvalid) state <= ST_DONE;
                ST_DONE:   state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            busAddr      <= {addr[31:2], 2'b00};   // bus sees word addresses only
            wdata        <= inWdata;
            wstrb        <= wmask;
            shamtReg     <= shamt;
            sizeReg      <= size;
            signReg      <= signExtend;
            resultTag    <= inTag;
            resultSqn    <= inSqn;
            resultIsLoad <= isLoad;
        end
        if (state == ST_WAIT_B && bvalid) begin
            resultData <= 32'd0;
            resultErr  <= (bresp != AXI_OKAY);
        end
        if (state == ST_WAIT_R && rvalid) begin
            resultData <= loadValue;
            resultErr  <= (rresp != AXI_OKAY);
        end
    end

endmodule

// ==== source/lsuTop.sv ====
module lsuTop import lsuPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                issueValid,
    output logic                issueReady,
    input  instrWord            instr,
    input  logic [31:0]         srcA,
    input  logic [31:0]         srcB,
    input  logic [SqnWidth-1:0] sqn,
    input  logic [TagWidth-1:0] tag,
    input  logic                flushValid,
    input  logic [SqnWidth-1:0] flushSqn,
    output logic [31:0]         awaddr,
    output logic                awvalid,
    input  logic                awready,
    output logic [31:0]         wdata,
    output logic [3:0]          wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready,
    output logic [31:0]         araddr,
    output logic                arvalid,
    input  logic                arready,
    input  logic [31:0]         rdata,
    input  logic [1:0]          rresp,
    input  logic                rvalid,
    output logic                rready,
    output logic                resultValid,
    output logic [31:0]         resultData,
    output logic [TagWidth-1:0] resultTag,
    output logic [SqnWidth-1:0] resultSqn,
    output logic                resultIsLoad,
    output logic                resultErr
);

    // decode to address stage
    logic                decValid, decReady;
    lsuOp                decOp;
    logic [31:0]         decBase, decImm, decStoreData;
    logic [SqnWidth-1:0] decSqn;
    logic [TagWidth-1:0] decTag;

    // address stage to memory port
    logic                agValid, agReady, agSignExtend, agIsLoad;
    logic [31:0]         agAddr, agData;
    logic [3:0]          agMask;
    logic [1:0]          agShamt, agSize;
    logic [SqnWidth-1:0] agSqn;
    logic [TagWidth-1:0] agTag;

    lsuDecode decode (
        .clk, .rst, .flushValid, .flushSqn, .issueValid, .instr, .srcA, .srcB, .sqn, .tag,
        .outReady (decReady), .issueReady, .outValid (decValid), .op (decOp),
        .base (decBase), .imm (decImm), .storeData (decStoreData),
        .outSqn (decSqn), .outTag (decTag)
    );

    addrGen agen (
        .clk, .rst, .flushValid, .flushSqn, .inValid (decValid), .op (decOp),
        .base (decBase), .imm (decImm), .storeData (decStoreData),
        .inSqn (decSqn), .inTag (decTag), .outReady (agReady), .inReady (decReady),
        .outValid (agValid), .addr (agAddr), .wmask (agMask), .wdata (agData),
        .shamt (agShamt), .size (agSize), .signExtend (agSignExtend), .isLoad (agIsLoad),
        .outSqn (agSqn), .outTag (agTag)
    );

    memPort mem (
        .clk, .rst, .inValid (agValid), .addr (agAddr), .wmask (agMask), .inWdata (agData),
        .shamt (agShamt), .size (agSize), .signExtend (agSignExtend), .isLoad (agIsLoad),
        .inSqn (agSqn), .inTag (agTag), .inReady (agReady),
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .resultValid, .resultData, .resultTag, .resultSqn, .resultIsLoad, .resultErr
    );

endmodule

// ==== verif/lsu_assert.sv ====
module lsu_assert (
    input logic        clk,
    input logic        rst,
    input logic        awvalid, awready, wvalid, wready, arvalid, arready,
    input logic        resultValid,
    input logic [31:0] awaddr, wdata, araddr,
    input logic [3:0]  wstrb
);
    timeunit 1ns;
    timeprecision 1ps;

    // a raised valid keeps its payload until the slave takes it
    awHold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    wHold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid, wdata or wstrb changed before wready");

    arHold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    resetQuiet: assert property (@(posedge clk) rst |=> !resultValid)
        else $error("resultValid high while in reset");

    oneChannel: assert property (@(posedge clk) disable iff (rst) !(awvalid && arvalid))
        else $error("awvalid and arvalid high together");

endmodule

bind memPort lsu_assert checks (.*);

// ==== verif/tb_lsu.sv ====
module tb_lsu import lsuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumOps    = 400;
    localparam int ClkPeriod = 4;
    localparam int MemWords  = 64;

    logic                clk, rst, issueValid, issueReady, flushValid;
    instrWord            instr;
    logic [31:0]         srcA, srcB;
    logic [SqnWidth-1:0] sqn, flushSqn, nextSqn;
    logic [TagWidth-1:0] tag;
    logic [31:0]         awaddr, wdata, araddr, rdata, resultData;
    logic [3:0]          wstrb;
    logic [1:0]          bresp, rresp;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;
    logic                resultValid, resultIsLoad, resultErr;
    logic [TagWidth-1:0] resultTag;
    logic [SqnWidth-1:0] resultSqn;

    logic [31:0]         mem [MemWords];
    // expected ops, oldest first, pushed and popped together
    instrWord            qInstr[$];
    logic [31:0]         qBase[$];
    logic [31:0]         qData[$];
    logic [SqnWidth-1:0] qSqn[$];
    logic [TagWidth-1:0] qTag[$];

    integer seed = 32'h38c68f34;
    int     errors = 0;
    int     checks = 0;
    int     flushed = 0;

    lsuTop uut (.*);

    function automatic logic [31:0] immOf(instrWord w);
        if (w.stype.opcode == OPC_STORE)
            return {{20{w.stype.immHi[6]}}, w.stype.immHi, w.stype.immLo};
        return {{20{w.itype.imm[11]}}, w.itype.imm};
    endfunction

    function automatic logic [31:0] laneBits(logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // register value of a load from the word that holds the addressed byte
    function automatic logic [31:0] extractLoad(logic [2:0] f3, logic [31:0] word,
                                                logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'd0, b};
            3'b101:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        errors++;
        $display("[ERROR] %s: expected %h, actual %h at %0t", name, expVal, actVal, $time);
    endtask

    task automatic reportFailure(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic driveRandomOp(output bit memOp);
        logic [31:0] r;
        logic [11:0] immVal;
        logic [2:0]  pick;
        int          kind;
        r = $random(seed);
        kind = r[31:28];
        immVal = {{7{r[4]}}, r[4:0]};   // small offsets keep most accesses inside the memory
        pick = r[7:5] % 3'd5;
        memOp = kind < 14;
        if (kind < 6)
            instr = {immVal[11:5], r[12:8], r[17:13], 3'(pick % 3), immVal[4:0], OPC_STORE};
        else if (kind < 14)
            instr = {immVal, r[17:13], pick < 3 ? pick : pick + 3'd1, r[22:18], OPC_LOAD};
        else if (kind == 14)
            instr = {immVal, r[17:13], 3'b011, r[22:18], OPC_LOAD};   // no such load width
        else
            instr = {r[31:7], 7'b0010011};
        r = $random(seed);
        // one base in sixteen points past the memory
        srcA = (r[31:28] == 4'd0) ? 32'h400 + r[7:0] : 32'd16 + r[15:8] % 32'd224;
        tag = r[20:16];
        srcB = $random(seed);
    endtask

    // ready for each request channel after 0 to 3 cycles, then a response after 0 to 3 more
    task automatic takeRequest(input bit isWrite);
        int aWait, wWait, n, d;
        bit aDone, wDone;
        aWait = $random(seed) & 3;
        wWait = $random(seed) & 3;
        aDone = 1'b0;
        wDone = !isWrite;
        n = 0;
        while (!(aDone && wDone)) begin
            awready = isWrite && !aDone && n >= aWait;
            arready = !isWrite && !aDone && n >= aWait;
            wready  = !wDone && n >= wWait;
            @(posedge clk);
            #1;
            aDone = aDone || awready || arready;
            wDone = wDone || wready;
            n++;
        end
        awready = 1'b0;
        arready = 1'b0;
        wready  = 1'b0;
        d = $random(seed) & 3;
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic serveAccess(input bit isWrite);
        logic [31:0] busAddr, ea, b, expData, lanes, wordIn;
        logic [3:0]  expStrb, strbIn;
        logic [2:0]  f3;
        bit          inRange;
        int          i;
        busAddr = isWrite ? awaddr : araddr;
        wordIn = wdata;
        strbIn = wstrb;
        inRange = busAddr < MemWords * 4;
        if (isWrite && wvalid !== 1'b1)
            reportFailure("wvalid not raised together with awvalid");
        if (qSqn.size() == 0 || isWrite != (qInstr[0].stype.opcode == OPC_STORE)) begin
            reportFailure("bus access does not match the oldest outstanding op");
        end else begin
            ea = qBase[0] + immOf(qInstr[0]);
            checks++;
            if (busAddr !== {ea[31:2], 2'b00})
                reportMismatch("bus address", {ea[31:2], 2'b00}, busAddr);
            if (isWrite) begin
                f3 = qInstr[0].stype.funct3;
                b = qData[0];
                for (i = 0; i < 4; i++) begin
                    // a byte store owns lane ea[1:0], a half store the half picked by ea[1]
                    case (f3)
                        3'b000:  expStrb[i] = (i == ea[1:0]);
                        3'b001:  expStrb[i] = (i / 2 == ea[1]);
                        default: expStrb[i] = 1'b1;
                    endcase
                end
                expData = (f3 == 3'b000) ? {4{b[7:0]}} : (f3 == 3'b001) ? {2{b[15:0]}} : b;
                lanes = laneBits(expStrb);
                if (strbIn !== expStrb)
                    reportMismatch("store strobe", 32'(expStrb), 32'(strbIn));
                if ((wordIn & lanes) !== (expData & lanes))
                    reportMismatch("store data", expData & lanes, wordIn & lanes);
            end
        end
        takeRequest(isWrite);
        for (i = 0; i < 4; i++) begin
            if (isWrite && inRange && strbIn[i])
                mem[busAddr[7:2]][8*i +: 8] = wordIn[8*i +: 8];
        end
        bresp = inRange ? AXI_OKAY : 2'b10;
        rresp = bresp;
        rdata = inRange ? mem[busAddr[7:2]] : $random(seed);
        bvalid = isWrite;
        rvalid = !isWrite;
        if ((isWrite ? bready : rready) !== 1'b1)
            reportFailure("response ready low while the response is presented");
        @(posedge clk);
        #1;
        bvalid = 1'b0;
        rvalid = 1'b0;
    endtask

    task automatic checkResult();
        instrWord            w;
        logic [31:0]         ea, expData;
        logic [SqnWidth-1:0] expSqn;
        logic [TagWidth-1:0] expTag;
        bit                  isStore, expErr;
        if (qSqn.size() == 0) begin
            reportFailure("result arrived with no op outstanding");
            return;
        end
        w = qInstr.pop_front();
        ea = qBase.pop_front() + immOf(w);
        void'(qData.pop_front());
        expSqn = qSqn.pop_front();
        expTag = qTag.pop_front();
        isStore = (w.stype.opcode == OPC_STORE);
        expErr = ea >= MemWords * 4;
        expData = isStore ? 32'd0 : extractLoad(w.itype.funct3, mem[ea[7:2]], ea[1:0]);
        checks++;
        if (resultSqn !== expSqn) reportMismatch("result sqn", 32'(expSqn), 32'(resultSqn));
        if (resultTag !== expTag) reportMismatch("result tag", 32'(expTag), 32'(resultTag));
        if (resultIsLoad !== !isStore)
            reportMismatch("result load flag", 32'(!isStore), 32'(resultIsLoad));
        if (resultErr !== expErr) reportMismatch("result error flag", 32'(expErr), 32'(resultErr));
        if ((isStore || !expErr) && resultData !== expData)
            reportMismatch(isStore ? "store result data" : "load data", expData, resultData);
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(NumOps * 40 * ClkPeriod);
        $display("timeout: %0d ops still outstanding after %0d cycles", qSqn.size(), NumOps * 40);
        $display("RESULT: FAIL");
        $finish;
    end

    // AXI slave, one access at a time
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (awvalid === 1'b1 || arvalid === 1'b1)) serveAccess(awvalid === 1'b1);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (resultValid === 1'b1) checkResult();
        end
    end

    initial begin
        logic [31:0] r;
        bit          memOp;
        int          i;
        int          issued;
        rst = 1'b1;
        issueValid = 1'b0;
        instr = '0;
        srcA = '0;
        srcB = '0;
        sqn = '0;
        tag = '0;
        flushValid = 1'b0;
        flushSqn = '0;
        awready = 1'b0;
        wready = 1'b0;
        bresp = AXI_OKAY;
        bvalid = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rresp = AXI_OKAY;
        rvalid = 1'b0;
        nextSqn = '0;
        issued = 0;
        for (i = 0; i < MemWords; i++) mem[i] = $random(seed);
        repeat (5) @(posedge clk);
        #1;
        // issue open, bus idle, responses always accepted
        checks++;
        if ({issueReady, bready, rready, awvalid, wvalid, arvalid, resultValid} !== 7'b1110000)
            reportMismatch("outputs after reset", 32'b1110000,
                           32'({issueReady, bready, rready, awvalid, wvalid, arvalid,
                                resultValid}));
        rst = 1'b0;
        while (issued < NumOps) begin
            @(posedge clk);
            #1;
            flushValid = 1'b0;
            issueValid = 1'b0;
            r = $random(seed);
            if (r[3:0] != 4'd0) begin   // an idle cycle now and then
                driveRandomOp(memOp);
                issueValid = 1'b1;
                sqn = nextSqn;
                // the branch is the newest accepted op, so only the presented op is younger
                flushValid = (r[7:4] == 4'd0);
                flushSqn = nextSqn - 1'b1;
                #2;
                if (flushValid) begin
                    flushed++;
                end else if (issueReady) begin
                    if (memOp) begin
                        qInstr.push_back(instr);
                        qBase.push_back(srcA);
                        qData.push_back(srcB);
                        qSqn.push_back(sqn);
                        qTag.push_back(tag);
                    end
                    nextSqn = nextSqn + 1'b1;
                    issued++;
                end
            end
        end
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        flushValid = 1'b0;
        while (qSqn.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);   // any late extra result shows up here
        $display("checks %0d, errors %0d, flushed ops %0d", checks, errors, flushed);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/lsuPkg.sv
source/loadAlign.sv
source/lsuDecode.sv
source/addrGen.sv
source/memPort.sv
source/lsuTop.sv
verif/lsu_assert.sv
verif/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_lsu -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
